/* hw/flash_bus_pkg.sv */
package flash_bus_pkg;

    // ------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------
    // word address on a x16 part
    typedef logic [25:1] flash_addr_t;
    typedef logic [15:0] flash_word_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cycle_op_t;

    // ------------------------------------------------------------------
    // command set, sent in the low byte
    // ------------------------------------------------------------------
    localparam logic [7:0] CMD_READ_ARRAY = 8'hFF;
    localparam logic [7:0] CMD_CLEAR_SR   = 8'h50;
    localparam logic [7:0] CMD_UNLOCK     = 8'h60;
    localparam logic [7:0] CMD_CONFIRM    = 8'hD0;
    localparam logic [7:0] CMD_ERASE      = 8'h20;
    localparam logic [7:0] CMD_PROGRAM    = 8'h40;

    // status register bits
    localparam int SR_READY     = 7;
    localparam int SR_ERASE_ERR = 5;
    localparam int SR_PROG_ERR  = 4;

    // slots of one asynchronous bus cycle
    localparam logic [2:0] SLOT_ADDR   = 3'd0;
    localparam logic [2:0] SLOT_STROBE = 3'd1;
    localparam logic [2:0] SLOT_ENABLE = 3'd2;
    localparam logic [2:0] SLOT_DRIVE  = 3'd3;
    localparam logic [2:0] SLOT_SAMPLE = 3'd6;
    localparam logic [2:0] SLOT_END    = 3'd7;

endpackage

/* hw/boot_table_pkg.sv */
package boot_table_pkg;

    // image select towards the parallel flash loader
    typedef logic [1:0] image_sel_t;

    localparam image_sel_t IMG_FACTORY = 2'b00;
    localparam image_sel_t IMG_ONE     = 2'b01;
    localparam image_sel_t IMG_TWO     = 2'b10;

    // ------------------------------------------------------------------
    // firmware codes, top six bits of the table word
    // ------------------------------------------------------------------
    typedef logic [5:0] fw_code_t;

    localparam fw_code_t CODE_IMG1_A  = 6'b100101;
    localparam fw_code_t CODE_IMG1_B  = 6'b101100;
    localparam fw_code_t CODE_IMG2    = 6'b110110;
    localparam fw_code_t CODE_FACTORY = 6'b111111;

    typedef enum logic {
        REQ_SELECT = 1'b0,
        REQ_UPDATE = 1'b1
    } req_kind_t;

    // word address of the configuration table
    localparam logic [25:1] DEFAULT_TABLE_ADDR = 25'h0008000;

endpackage

/* hw/ctrl_ifs.sv */
`timescale 1ns/10ps

// ----------------------------------------------------------------------
// request from the intake to the sequencer
// ----------------------------------------------------------------------
interface boot_req_if import flash_bus_pkg::*, boot_table_pkg::*; ();
    logic        valid;
    logic        ready;
    req_kind_t   kind;
    // only meaningful for updates
    flash_word_t word;

    modport src (output valid, kind, word, input ready);
    modport dst (input valid, kind, word, output ready);
endinterface

// ----------------------------------------------------------------------
// one bus cycle, sequencer to bus engine
// ----------------------------------------------------------------------
interface flash_cycle_if import flash_bus_pkg::*; ();
    logic        start;
    cycle_op_t   op;
    flash_addr_t addr;
    flash_word_t wdata;
    flash_word_t rdata;
    logic        done;

    modport master (output start, op, addr, wdata, input rdata, done);
    modport engine (input start, op, addr, wdata, output rdata, done);
endinterface

// table word and status towards the decoder
interface boot_result_if import flash_bus_pkg::*; ();
    logic        result_valid;
    flash_word_t firm_word;
    logic        fail;
    logic        busy;

    modport src (output result_valid, firm_word, fail, busy);
    modport dst (input result_valid, firm_word, fail, busy);
endinterface

/* hw/boot_request_intake.sv */
`timescale 1ns/10ps

module boot_request_intake import flash_bus_pkg::*, boot_table_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        fc_req,
    input  logic        upd_req,
    input  flash_word_t upd_word,
    boot_req_if.src     req
);

    // two sync flops plus one for edge detect
    logic [2:0] fc_sync;
    logic       fc_fall;

    // old level high and new level low
    assign fc_fall = fc_sync[2] & ~fc_sync[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // request is idle high
            fc_sync   <= 3'b111;
            req.valid <= 1'b0;
            req.kind  <= REQ_SELECT;
        end else begin
            fc_sync <= {fc_sync[1:0], fc_req};
            if (req.valid) begin
                // hold until the sequencer takes it
                if (req.ready) begin
                    req.valid <= 1'b0;
                end
            end else if (upd_req) begin
                req.valid <= 1'b1;
                req.kind  <= REQ_UPDATE;
            end else if (fc_fall) begin
                req.valid <= 1'b1;
                req.kind  <= REQ_SELECT;
            end
        end
    end

    // update word captured with the request
    always_ff @(posedge clk) begin
        if (!req.valid && upd_req) begin
            req.word <= upd_word;
        end
    end

    a_hold_stable : assert property (@(posedge clk) disable iff (!arst_n)
        (req.valid && !req.ready) |=> ($stable(req.kind) && $stable(req.word)));

endmodule

/* hw/flash_bus_cycle.sv */
`timescale 1ns/10ps

module flash_bus_cycle import flash_bus_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  flash_word_t   dq_in,
    flash_cycle_if.engine cyc,
    output logic          flash_advn,
    output logic          flash_cen,
    output logic          flash_oen,
    output logic          flash_wen,
    output flash_addr_t   flash_a,
    output flash_word_t   dq_out,
    output logic          dq_oe
);

    logic [2:0] slot;
    logic       running;
    cycle_op_t  op_q;

    // ------------------------------------------------------------------
    // strobes and slot counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot       <= SLOT_ADDR;
            running    <= 1'b0;
            op_q       <= OP_READ;
            flash_advn <= 1'b1;
            flash_cen  <= 1'b1;
            flash_oen  <= 1'b1;
            flash_wen  <= 1'b1;
            dq_oe      <= 1'b0;
            cyc.done   <= 1'b0;
        end else begin
            cyc.done <= 1'b0;
            if (!running) begin
                // start edge is slot 0
                if (cyc.start) begin
                    running    <= 1'b1;
                    slot       <= SLOT_STROBE;
                    op_q       <= cyc.op;
                    flash_advn <= 1'b1;
                end
            end else begin
                slot <= slot + 3'd1;
                case (slot)
                    SLOT_STROBE: begin
                        flash_advn <= 1'b0;
                        flash_cen  <= 1'b0;
                    end
                    SLOT_ENABLE: begin
                        flash_advn <= 1'b1;
                        flash_oen  <= (op_q != OP_READ);
                        flash_wen  <= (op_q != OP_WRITE);
                    end
                    // data drive on writes only
                    SLOT_DRIVE: dq_oe <= (op_q == OP_WRITE);
                    SLOT_END: begin
                        flash_cen <= 1'b1;
                        flash_oen <= 1'b1;
                        flash_wen <= 1'b1;
                        dq_oe     <= 1'b0;
                        cyc.done  <= 1'b1;
                        running   <= 1'b0;
                        slot      <= SLOT_ADDR;
                    end
                    default: ;
                endcase
            end
        end
    end

    // address, write data and read sample
    always_ff @(posedge clk) begin
        if (!running && cyc.start) begin
            flash_a <= cyc.addr;
            dq_out  <= cyc.wdata;
        end
        if (running && slot == SLOT_SAMPLE && op_q == OP_READ) begin
            cyc.rdata <= dq_in;
        end
    end

    a_no_contention : assert property (@(posedge clk) disable iff (!arst_n)
        !(dq_oe && !flash_oen));
    a_start_idle : assert property (@(posedge clk) disable iff (!arst_n)
        cyc.start |-> !running);

endmodule

/* hw/boot_sequencer.sv */
`timescale 1ns/10ps

module boot_sequencer import flash_bus_pkg::*, boot_table_pkg::*; #(
    parameter flash_addr_t TABLE_ADDR  = DEFAULT_TABLE_ADDR,
    parameter int          POLL_LIMIT  = 64,
    parameter int          RETRY_LIMIT = 2
) (
    input  logic          clk,
    input  logic          arst_n,
    boot_req_if.dst       req,
    flash_cycle_if.master cyc,
    boot_result_if.src    res
);

    localparam int PW = $clog2(POLL_LIMIT + 1);
    localparam int RW = $clog2(RETRY_LIMIT + 2);
    localparam logic [PW-1:0] POLL_LAST  = PW'(POLL_LIMIT - 1);
    localparam logic [RW-1:0] RETRY_LAST = RW'(RETRY_LIMIT);

    // one state per bus cycle
    typedef enum logic [3:0] {
        S_IDLE, S_RD_ARRAY, S_RD_TABLE, S_CLR_SR, S_UNLOCK, S_UNLOCK_CF,
        S_ERASE, S_ERASE_CF, S_ERASE_POLL, S_ERASE_CLR,
        S_PROG, S_PROG_DATA, S_PROG_POLL, S_PROG_CLR
    } seq_state_t;

    seq_state_t      state;
    logic            issued;
    logic [PW-1:0]   poll_cnt;
    logic [RW-1:0]   retry_cnt;
    logic [7:0]      cmd;
    logic            sr_error;
    logic            give_up;
    flash_word_t     word_q;

    // ------------------------------------------------------------------
    // cycle request, all from the table address
    // ------------------------------------------------------------------
    always_comb begin
        case (state)
            S_CLR_SR, S_ERASE_CLR, S_PROG_CLR: cmd = CMD_CLEAR_SR;
            S_UNLOCK:                          cmd = CMD_UNLOCK;
            S_UNLOCK_CF, S_ERASE_CF:           cmd = CMD_CONFIRM;
            S_ERASE:                           cmd = CMD_ERASE;
            S_PROG:                            cmd = CMD_PROGRAM;
            default:                           cmd = CMD_READ_ARRAY;
        endcase
    end

    // start once per state, the done clock is the decision
    assign cyc.start = (state != S_IDLE) && !issued;
    assign cyc.addr  = TABLE_ADDR;
    assign cyc.wdata = (state == S_PROG_DATA) ? word_q : {8'h00, cmd};
    assign cyc.op    = (state == S_RD_TABLE || state == S_ERASE_POLL ||
                        state == S_PROG_POLL) ? OP_READ : OP_WRITE;
    assign req.ready = (state == S_IDLE);

    // status evaluation on a polled read
    assign sr_error = cyc.rdata[SR_ERASE_ERR] | cyc.rdata[SR_PROG_ERR];
    assign give_up  = cyc.rdata[SR_READY] ? (sr_error && retry_cnt == RETRY_LAST)
                                          : (poll_cnt == POLL_LAST);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state            <= S_IDLE;
            issued           <= 1'b0;
            poll_cnt         <= '0;
            retry_cnt        <= '0;
            res.result_valid <= 1'b0;
            res.fail         <= 1'b0;
            res.busy         <= 1'b0;
        end else begin
            res.result_valid <= 1'b0;
            res.fail         <= 1'b0;
            if (cyc.start) begin
                issued <= 1'b1;
            end
            if (state == S_IDLE) begin
                if (req.valid) begin
                    res.busy  <= 1'b1;
                    poll_cnt  <= '0;
                    retry_cnt <= '0;
                    state     <= (req.kind == REQ_UPDATE) ? S_CLR_SR : S_RD_ARRAY;
                end
            end else if (cyc.done) begin
                issued <= 1'b0;
                case (state)
                    S_CLR_SR:    state <= S_UNLOCK;
                    S_UNLOCK:    state <= S_UNLOCK_CF;
                    S_UNLOCK_CF: state <= S_ERASE;
                    S_ERASE:     state <= S_ERASE_CF;
                    S_ERASE_CF:  state <= S_ERASE_POLL;
                    S_ERASE_CLR: state <= S_ERASE;
                    S_PROG:      state <= S_PROG_DATA;
                    S_PROG_DATA: state <= S_PROG_POLL;
                    S_PROG_CLR:  state <= S_PROG;
                    S_RD_ARRAY:  state <= S_RD_TABLE;
                    S_RD_TABLE: begin
                        res.result_valid <= 1'b1;
                        res.busy         <= 1'b0;
                        state            <= S_IDLE;
                    end
                    // erase and program polling share the rules
                    S_ERASE_POLL, S_PROG_POLL: begin
                        if (give_up) begin
                            res.fail <= 1'b1;
                            res.busy <= 1'b0;
                            state    <= S_IDLE;
                        end else if (!cyc.rdata[SR_READY]) begin
                            poll_cnt <= poll_cnt + 1'b1;
                        end else if (sr_error) begin
                            // clear status, then repeat the step
                            poll_cnt  <= '0;
                            retry_cnt <= retry_cnt + 1'b1;
                            state     <= (state == S_PROG_POLL) ? S_PROG_CLR : S_ERASE_CLR;
                        end else begin
                            poll_cnt  <= '0;
                            retry_cnt <= '0;
                            state     <= (state == S_PROG_POLL) ? S_RD_ARRAY : S_PROG;
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (req.valid && req.ready) begin
            word_q <= req.word;
        end
        if (state == S_RD_TABLE && cyc.done) begin
            res.firm_word <= cyc.rdata;
        end
    end

    a_one_outcome : assert property (@(posedge clk) disable iff (!arst_n)
        !(res.result_valid && res.fail));

endmodule

/* hw/image_select_decode.sv */
`timescale 1ns/10ps

module image_select_decode import boot_table_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    boot_result_if.dst  res,
    output image_sel_t  pfl_str,
    output logic        wr_done,
    output logic        boot_error,
    output logic [7:0]  fc_user_led
);

    fw_code_t code;
    logic     busy_q;

    // firmware code sits in the top six bits
    assign code = res.firm_word[15:10];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pfl_str     <= IMG_FACTORY;
            wr_done     <= 1'b0;
            boot_error  <= 1'b0;
            fc_user_led <= 8'h00;
            busy_q      <= 1'b0;
        end else begin
            busy_q <= res.busy;
            // new request clears the flags
            if (res.busy && !busy_q) begin
                wr_done    <= 1'b0;
                boot_error <= 1'b0;
            end
            if (res.fail) begin
                boot_error <= 1'b1;
            end else if (res.result_valid) begin
                fc_user_led <= res.firm_word[15:8];
                case (code)
                    CODE_IMG1_A, CODE_IMG1_B: begin
                        pfl_str <= IMG_ONE;
                        wr_done <= 1'b1;
                    end
                    CODE_IMG2: begin
                        pfl_str <= IMG_TWO;
                        wr_done <= 1'b1;
                    end
                    CODE_FACTORY: begin
                        pfl_str <= IMG_FACTORY;
                        wr_done <= 1'b1;
                    end
                    // unknown code keeps the old select
                    default: boot_error <= 1'b1;
                endcase
            end
        end
    end

endmodule

/* hw/flash_boot_ctrl.sv */
`timescale 1ns/10ps

module flash_boot_ctrl import flash_bus_pkg::*, boot_table_pkg::*; #(
    parameter flash_addr_t TABLE_ADDR  = DEFAULT_TABLE_ADDR,
    parameter int          POLL_LIMIT  = 64,
    parameter int          RETRY_LIMIT = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        fc_req,
    input  logic        upd_req,
    input  flash_word_t upd_word,
    input  flash_word_t fc_fsm_d_in,
    output flash_word_t fc_fsm_d_out,
    output logic        fc_fsm_d_oe,
    output flash_addr_t fc_fsm_a,
    output logic        fc_flash_advn,
    output logic        fc_flash_cen,
    output logic        fc_flash_oen,
    output logic        fc_flash_wen,
    output logic [7:0]  fc_user_led,
    output image_sel_t  pfl_str,
    output logic        wr_done,
    output logic        boot_error
);

    boot_req_if    req_bus ();
    flash_cycle_if cyc_bus ();
    boot_result_if res_bus ();

    // ------------------------------------------------------------------
    // request side
    // ------------------------------------------------------------------
    boot_request_intake i_intake (
        .clk      (clk),
        .arst_n   (arst_n),
        .fc_req   (fc_req),
        .upd_req  (upd_req),
        .upd_word (upd_word),
        .req      (req_bus.src)
    );

    boot_sequencer #(
        .TABLE_ADDR  (TABLE_ADDR),
        .POLL_LIMIT  (POLL_LIMIT),
        .RETRY_LIMIT (RETRY_LIMIT)
    ) i_sequencer (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req_bus.dst),
        .cyc    (cyc_bus.master),
        .res    (res_bus.src)
    );

    // flash pins
    flash_bus_cycle i_bus_cycle (
        .clk        (clk),
        .arst_n     (arst_n),
        .dq_in      (fc_fsm_d_in),
        .cyc        (cyc_bus.engine),
        .flash_advn (fc_flash_advn),
        .flash_cen  (fc_flash_cen),
        .flash_oen  (fc_flash_oen),
        .flash_wen  (fc_flash_wen),
        .flash_a    (fc_fsm_a),
        .dq_out     (fc_fsm_d_out),
        .dq_oe      (fc_fsm_d_oe)
    );

    image_select_decode i_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .res         (res_bus.dst),
        .pfl_str     (pfl_str),
        .wr_done     (wr_done),
        .boot_error  (boot_error),
        .fc_user_led (fc_user_led)
    );

endmodule

/* bench/flash_model.sv */
`timescale 1ns/10ps

module flash_model import flash_bus_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  flash_addr_t flash_a,
    input  logic        flash_advn,
    input  logic        flash_cen,
    input  logic        flash_oen,
    input  logic        flash_wen,
    input  flash_word_t dq_out,
    input  logic        dq_oe,
    output flash_word_t dq_in,
    // bench control
    input  flash_addr_t table_addr,
    input  logic        load_en,
    input  flash_word_t load_word,
    input  logic        inject_en,
    input  logic [3:0]  inject_errs,
    output flash_word_t peek_word
);

    typedef enum logic [1:0] {PEND_NONE, PEND_UNLOCK, PEND_ERASE, PEND_PROG} pend_t;

    flash_word_t mem [256];
    flash_addr_t addr_q;
    pend_t       pend;
    pend_t       pend_q;
    logic        status_mode;
    logic        erase_err;
    logic [3:0]  erase_errs;
    int          busy_reads;
    logic        wen_q;
    logic        oen_q;
    logic [7:0]  status;
    logic [7:0]  cmd;
    logic [7:0]  idx;

    assign idx       = addr_q[8:1];
    assign cmd       = dq_out[7:0];
    assign peek_word = mem[table_addr[8:1]];

    // not ready for the first three status reads
    always_comb begin
        status               = 8'h00;
        status[SR_READY]     = (busy_reads >= 3);
        status[SR_ERASE_ERR] = erase_err;
    end

    // resolved data bus, controller drive wins
    assign dq_in = dq_oe ? dq_out :
                   (!flash_oen && !flash_cen) ? (status_mode ? {8'h00, status} : mem[idx]) :
                   16'hFFFF;

    // ------------------------------------------------------------------
    // command decoder, runs on the end of a write strobe
    // ------------------------------------------------------------------
    task decode_write();
        pend = PEND_NONE;
        if (pend_q == PEND_PROG) begin
            mem[idx]    = mem[idx] & dq_out;
            status_mode = 1'b1;
            busy_reads  = 0;
        end else if (pend_q == PEND_ERASE && cmd == CMD_CONFIRM) begin
            status_mode = 1'b1;
            busy_reads  = 0;
            // injected failure leaves the block as it was
            if (erase_errs != 4'd0) begin
                erase_err  = 1'b1;
                erase_errs = erase_errs - 4'd1;
            end else begin
                mem[idx] = 16'hFFFF;
            end
        end else if (!(pend_q == PEND_UNLOCK && cmd == CMD_CONFIRM)) begin
            case (cmd)
                CMD_READ_ARRAY: status_mode = 1'b0;
                CMD_CLEAR_SR:   erase_err = 1'b0;
                CMD_UNLOCK:     pend = PEND_UNLOCK;
                CMD_ERASE:      pend = PEND_ERASE;
                CMD_PROGRAM:    pend = PEND_PROG;
                default: ;
            endcase
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            // fill from the whole index
            for (int i = 0; i < 256; i++) begin
                mem[i] = 16'(i) * 16'h9E37 ^ 16'h5A5A;
            end
            addr_q      = '0;
            pend        = PEND_NONE;
            status_mode = 1'b0;
            erase_err   = 1'b0;
            erase_errs  = 4'd0;
            busy_reads  = 0;
            wen_q       = 1'b1;
            oen_q       = 1'b1;
        end else begin
            if (!flash_advn) begin
                addr_q = flash_a;
            end
            if (load_en) begin
                mem[table_addr[8:1]] = load_word;
            end
            if (inject_en) begin
                erase_errs = inject_errs;
            end
            if (flash_wen && !wen_q) begin
                pend_q = pend;
                decode_write();
            end
            // one status read done
            if (flash_oen && !oen_q && status_mode) begin
                busy_reads = busy_reads + 1;
            end
            wen_q = flash_wen;
            oen_q = flash_oen;
        end
    end

endmodule

/* bench/tb_flash_boot_ctrl.sv */
`timescale 1ns/10ps

module tb_flash_boot_ctrl import flash_bus_pkg::*, boot_table_pkg::*; ();

    localparam int RETRY_LIMIT = 2;
    localparam int WAIT_LIMIT  = 4000;
    localparam int NUM_ROWS    = 9;
    localparam int DRIVE_DELAY = 5;

    // one stimulus row, ok means wr_done expected
    typedef struct packed {
        req_kind_t  kind;
        fw_code_t   code;
        logic [3:0] errs;
        image_sel_t img;
        logic       ok;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        fc_req;
    logic        upd_req;
    flash_word_t upd_word;
    flash_word_t fc_fsm_d_in;
    flash_word_t fc_fsm_d_out;
    logic        fc_fsm_d_oe;
    flash_addr_t fc_fsm_a;
    logic        fc_flash_advn;
    logic        fc_flash_cen;
    logic        fc_flash_oen;
    logic        fc_flash_wen;
    logic [7:0]  fc_user_led;
    image_sel_t  pfl_str;
    logic        wr_done;
    logic        boot_error;

    // flash model control
    logic        load_en;
    flash_word_t load_word;
    logic        inject_en;
    logic [3:0]  inject_errs;
    flash_word_t peek_word;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr_state;
    flash_word_t cur_word;
    logic [7:0]  exp_led;

    flash_boot_ctrl i_dut (.*);

    flash_model i_flash (
        .clk         (clk),
        .arst_n      (arst_n),
        .flash_a     (fc_fsm_a),
        .flash_advn  (fc_flash_advn),
        .flash_cen   (fc_flash_cen),
        .flash_oen   (fc_flash_oen),
        .flash_wen   (fc_flash_wen),
        .dq_out      (fc_fsm_d_out),
        .dq_oe       (fc_fsm_d_oe),
        .dq_in       (fc_fsm_d_in),
        .table_addr  (DEFAULT_TABLE_ADDR),
        .load_en     (load_en),
        .load_word   (load_word),
        .inject_en   (inject_en),
        .inject_errs (inject_errs),
        .peek_word   (peek_word)
    );

    always #20 clk = ~clk;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic step_clock();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_image(input image_sel_t got, input image_sel_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input flash_word_t got, input flash_word_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input flash_addr_t got, input flash_addr_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // want_set low waits for both flags to drop, high for either to rise
    task automatic wait_flags(input logic want_set, input int num);
        int n;
        n = 0;
        while ((wr_done || boot_error) != want_set) begin
            step_clock();
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout in row %0d: wr_done and boot_error never went %b",
                         num, want_set);
                stop_run();
            end
        end
    endtask

    // ------------------------------------------------------------------
    // one table row
    // ------------------------------------------------------------------
    task automatic run_row(input int num, input row_t row);
        logic [15:0] low;
        flash_word_t word;
        rand_bits(10, low);
        word = {row.code, low[9:0]};
        repeat (4) step_clock();
        inject_errs = row.errs;
        inject_en   = 1'b1;
        // select reads a preloaded table word
        if (row.kind == REQ_SELECT) begin
            load_word = word;
            load_en   = 1'b1;
            cur_word  = word;
        end
        step_clock();
        inject_en = 1'b0;
        load_en   = 1'b0;
        if (row.kind == REQ_SELECT) begin
            fc_req = 1'b0;
        end else begin
            upd_word = word;
            upd_req  = 1'b1;
            step_clock();
            upd_req = 1'b0;
        end
        wait_flags(1'b0, num);
        wait_flags(1'b1, num);
        fc_req = 1'b1;
        // leds follow any word that was read back
        if (row.kind == REQ_SELECT || row.ok) begin
            exp_led = word[15:8];
        end
        if (row.kind == REQ_UPDATE && row.ok) begin
            cur_word = word;
        end
        check_flag(wr_done, row.ok, $sformatf("row %0d wr_done", num));
        check_flag(boot_error, !row.ok, $sformatf("row %0d boot_error", num));
        check_image(pfl_str, row.img, $sformatf("row %0d pfl_str", num));
        check_word({8'h00, fc_user_led}, {8'h00, exp_led}, $sformatf("row %0d leds", num));
        check_word(peek_word, cur_word, $sformatf("row %0d flash array", num));
        check_addr(fc_fsm_a, DEFAULT_TABLE_ADDR, $sformatf("row %0d flash address", num));
        check_flag(fc_fsm_d_oe, 1'b0, $sformatf("row %0d dq_oe at end", num));
        check_flag(fc_flash_cen, 1'b1, $sformatf("row %0d cen at end", num));
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        fc_req      = 1'b1;
        upd_req     = 1'b0;
        upd_word    = '0;
        load_en     = 1'b0;
        load_word   = '0;
        inject_en   = 1'b0;
        inject_errs = 4'd0;
        lfsr_state  = 32'h1c1e;
        cur_word    = '0;
        exp_led     = 8'h00;

        // kind, code, erase errors, expected select, wr_done expected
        rows[0] = '{REQ_SELECT, CODE_FACTORY, 4'd0, IMG_FACTORY, 1'b1};
        rows[1] = '{REQ_SELECT, CODE_IMG2, 4'd0, IMG_TWO, 1'b1};
        rows[2] = '{REQ_SELECT, 6'b010101, 4'd0, IMG_TWO, 1'b0};
        rows[3] = '{REQ_SELECT, CODE_IMG1_A, 4'd0, IMG_ONE, 1'b1};
        rows[4] = '{REQ_SELECT, CODE_IMG1_B, 4'd0, IMG_ONE, 1'b1};
        rows[5] = '{REQ_UPDATE, CODE_IMG2, 4'd0, IMG_TWO, 1'b1};
        rows[6] = '{REQ_UPDATE, CODE_FACTORY, 4'd1, IMG_FACTORY, 1'b1};
        rows[7] = '{REQ_UPDATE, CODE_IMG1_A, 4'(RETRY_LIMIT + 1), IMG_FACTORY, 1'b0};
        rows[8] = '{REQ_SELECT, CODE_IMG2, 4'd0, IMG_TWO, 1'b1};

        repeat (16) @(posedge clk);
        #(DRIVE_DELAY);
        // idle levels while in reset
        check_flag(fc_flash_cen, 1'b1, "cen in reset");
        check_flag(fc_flash_oen, 1'b1, "oen in reset");
        check_flag(fc_flash_wen, 1'b1, "wen in reset");
        check_flag(fc_flash_advn, 1'b1, "advn in reset");
        check_flag(fc_fsm_d_oe, 1'b0, "dq_oe in reset");
        check_flag(wr_done, 1'b0, "wr_done in reset");
        check_flag(boot_error, 1'b0, "boot_error in reset");
        check_image(pfl_str, IMG_FACTORY, "pfl_str in reset");
        arst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r, rows[r]);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog.f */
hw/flash_bus_pkg.sv
hw/boot_table_pkg.sv
hw/ctrl_ifs.sv
hw/boot_request_intake.sv
hw/flash_bus_cycle.sv
hw/boot_sequencer.sv
hw/image_select_decode.sv
hw/flash_boot_ctrl.sv
bench/flash_model.sv
bench/tb_flash_boot_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_flash_boot_ctrl --Mdir obj_dir -o tb_flash_boot_ctrl
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_flash_boot_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
